/* Bender.yml */
package:
  name: mapper

sources:
  - rtl/mapper_pkg.sv
  - rtl/mapper_regs.sv
  - rtl/region_decode.sv
  - rtl/dtack_gen.sv
  - rtl/irq_ctrl.sv
  - rtl/mapper_top.sv
  - target: test
    files:
      - bench/mapper_tb.sv

/* bench/mapper_tb.sv */
`timescale 1ns/1ps

module mapper_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int STIM_DELAY  = 5;
    localparam int N_WRITES    = 48;
    localparam int N_ADDRS     = 96;
    // reset, writes, readback, region sweep, plus the short directed tests
    localparam int TEST_CYCLES = 8 + N_WRITES + 33 + 2 * mapper_pkg::NUM_REGIONS + N_ADDRS + 80;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD;

    logic                  clk = 1'b0;
    logic                  rst;
    mapper_pkg::host_req_t host;
    mapper_pkg::cpu_bus_t  cpu;
    logic                  ext_dack_n, vint, snd_wr, snd_rd;
    logic [7:0]            snd_din;
    logic [7:0]            host_dout, active, snd_dout;
    logic [2:0]            ipl_n;
    logic                  dtack_n, vpa_n, snd_full, snd_intn, cpu_rst, cpu_halt_n;

    // reference model state
    logic [7:0]  regs [0:31];
    logic        model_full, model_intn;
    logic [7:0]  model_latch;
    logic [31:0] lcg_state = 32'd80;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mapper_top DUT (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);   // fold high bits into the weak low ones
    endfunction

    task automatic tick();
        @(posedge clk);
        #(STIM_DELAY);
    endtask

    task automatic check_eq(input string sig, input logic [31:0] expected,
                            input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL t=%0t %s expected 0x%0h actual 0x%0h", $time, sig, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic host_write(input logic [4:0] a, input logic [7:0] d);
        host = '{wr: 1'b1, rd: 1'b0, addr: a, data: d};
        tick();
        host = '0;
        regs[a] = d;
        if (a == mapper_pkg::REG_SND) begin
            model_full = 1'b1;
        end
    endtask

    // status word assumes CTRL was not written on the previous edge
    function automatic logic [7:0] read_expect(input logic [4:0] a);
        case (a)
            mapper_pkg::REG_CTRL: return {model_full, model_intn, regs[mapper_pkg::REG_CTRL][0],
                                          ~regs[mapper_pkg::REG_CTRL][1], 1'b0,
                                          regs[mapper_pkg::REG_IPL][2:0]};
            mapper_pkg::REG_SND:  return model_latch;
            default:              return regs[a];
        endcase
    endfunction

    task automatic host_read_check(input logic [4:0] a);
        logic [7:0] exp;
        exp  = read_expect(a);
        host = '{wr: 1'b0, rd: 1'b1, addr: a, data: 8'd0};
        tick();
        host = '0;
        if (a == mapper_pkg::REG_SND) begin
            model_intn = 1'b1;  // host took the byte
        end
        check_eq("host_dout", exp, host_dout);
        check_eq("snd_intn", model_intn, snd_intn);
    endtask

    function automatic logic region_hit(input logic [7:0] cfg, input logic [7:0] base,
                                        input logic [23:1] a);
        case (cfg[1:0])
            mapper_pkg::SIZE_64K:  return a[23:16] == base;
            mapper_pkg::SIZE_128K: return a[23:17] == base[7:1];
            mapper_pkg::SIZE_512K: return a[23:19] == base[7:3];
            default:               return a[23:21] == base[7:5];
        endcase
    endfunction

    function automatic logic [7:0] expect_active(input logic [23:1] a);
        for (int i = 0; i < mapper_pkg::NUM_REGIONS; i++) begin
            if (region_hit(regs[mapper_pkg::REG_REGION0 + 2 * i], regs[17 + 2 * i], a)) begin
                return 8'd1 << i;   // lowest index wins
            end
        end
        return 8'd0;
    endfunction

    // edges from the first as_n low sample until dtack_n is seen low
    task automatic wait_dtack(output int edges);
        edges = 0;
        while (edges < 8) begin
            tick();
            edges++;
            if (!dtack_n) begin
                break;
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        int          n;
        logic [7:0]  b, d, base;
        logic [2:0]  lvl;
        logic [23:1] addr;
        rst        = 1'b1;
        host       = '0;
        cpu        = '{addr: '0, as_n: 1'b1, fc: 3'd0};
        ext_dack_n = 1'b1;
        vint       = 1'b0;
        snd_wr     = 1'b0;
        snd_din    = 8'd0;
        snd_rd     = 1'b0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 8'd0;
        end
        regs[mapper_pkg::REG_IPL] = 8'd7;
        model_full  = 1'b0;
        model_intn  = 1'b1;
        model_latch = 8'd0;
        repeat (4) @(posedge clk);
        #(STIM_DELAY);
        rst = 1'b0;
        check_eq("dtack_n", 1, dtack_n);
        check_eq("vpa_n", 1, vpa_n);
        check_eq("snd_intn", 1, snd_intn);
        check_eq("cpu_halt_n", 1, cpu_halt_n);
        check_eq("ipl_n", 7, ipl_n);
        check_eq("snd_full", 0, snd_full);
        check_eq("cpu_rst", 1, cpu_rst);   // one cycle past reset
        tick();
        check_eq("cpu_rst", 0, cpu_rst);

        // register file
        repeat (N_WRITES) host_write(5'(lcg_next()), 8'(lcg_next()));
        tick();
        for (int i = 0; i < 32; i++) begin
            host_read_check(5'(i));
        end

        // region priority
        for (int i = 0; i < mapper_pkg::NUM_REGIONS; i++) begin
            host_write(5'(mapper_pkg::REG_REGION0 + 2 * i), 8'(lcg_next()) & 8'h0f);
            host_write(5'(mapper_pkg::REG_REGION0 + 2 * i + 1), 8'(lcg_next()));
        end
        repeat (N_ADDRS) begin
            addr = 23'(lcg_next());
            if (lcg_next() % 2 == 0) begin
                addr[23:16] = regs[17 + 2 * (lcg_next() % 8)];  // aim inside some region
            end
            cpu = '{addr: addr, as_n: 1'b1, fc: 3'(lcg_next() % 7)};
            #1;
            check_eq("active", expect_active(addr), active);
            tick();
        end

        // dtack latency with region 0 set to 2M so it covers the address
        base = 8'(lcg_next());
        host_write(5'(mapper_pkg::REG_REGION0 + 1), base);
        for (int m = 0; m < 3; m++) begin
            host_write(mapper_pkg::REG_REGION0, 8'(m * 4 + 3));
            cpu = '{addr: {base[7:5], 20'(lcg_next())}, as_n: 1'b0, fc: 3'd5};
            #1;
            check_eq("active", 8'd1, active);
            wait_dtack(n);
            check_eq("dtack latency", m + 1, n);
            cpu.as_n = 1'b1;
            tick();
            check_eq("dtack_n", 1, dtack_n);
        end
        host_write(mapper_pkg::REG_REGION0, 8'h0f);   // 2M region on external ack
        cpu = '{addr: {base[7:5], 20'(lcg_next())}, as_n: 1'b0, fc: 3'd5};
        repeat (1 + lcg_next() % 4) begin
            tick();
            check_eq("dtack_n", 1, dtack_n);
        end
        ext_dack_n = 1'b0;
        tick();
        check_eq("dtack_n", 0, dtack_n);
        cpu.as_n   = 1'b1;
        ext_dack_n = 1'b1;
        tick();
        check_eq("dtack_n", 1, dtack_n);

        // interrupts
        lvl = 3'(lcg_next() % 3) + 3'd4;   // never the vblank level
        host_write(mapper_pkg::REG_IPL, {5'd0, lvl});
        check_eq("ipl_n", lvl, ipl_n);
        vint = 1'b1;
        tick();
        vint = 1'b0;
        check_eq("ipl_n", 3, ipl_n);
        tick();
        check_eq("ipl_n", 3, ipl_n);
        // address inside region 0 so only the ack can hold active at zero
        cpu = '{addr: {base[7:5], 20'(lcg_next())}, as_n: 1'b0, fc: 3'd7};
        #1;
        check_eq("vpa_n", 0, vpa_n);
        check_eq("active", 0, active);
        tick();
        regs[mapper_pkg::REG_IPL][2:0] = 3'd7;   // ack clears the programmed level
        cpu.as_n = 1'b1;
        #1;
        check_eq("vpa_n", 1, vpa_n);
        check_eq("ipl_n", regs[mapper_pkg::REG_IPL][2:0], ipl_n);
        tick();
        host_read_check(mapper_pkg::REG_IPL);

        // sound mailbox
        b = 8'(lcg_next());
        host_write(mapper_pkg::REG_SND, b);
        check_eq("snd_full", 1, snd_full);
        check_eq("snd_dout", regs[mapper_pkg::REG_SND], snd_dout);
        snd_rd = 1'b1;
        tick();
        snd_rd     = 1'b0;
        model_full = 1'b0;
        check_eq("snd_full", model_full, snd_full);
        snd_rd = 1'b1;
        host_write(mapper_pkg::REG_SND, ~b);    // same-cycle set beats clear
        snd_rd = 1'b0;
        check_eq("snd_full", model_full, snd_full);
        check_eq("snd_dout", regs[mapper_pkg::REG_SND], snd_dout);
        snd_rd = 1'b1;
        tick();
        snd_rd     = 1'b0;
        model_full = 1'b0;
        check_eq("snd_full", model_full, snd_full);
        d       = 8'(lcg_next());
        snd_din = d;
        snd_wr  = 1'b1;
        tick();
        snd_wr      = 1'b0;
        model_latch = d;
        model_intn  = 1'b0;
        check_eq("snd_intn", model_intn, snd_intn);
        host_read_check(mapper_pkg::REG_SND);

        // cpu reset and halt
        host_write(mapper_pkg::REG_CTRL, 8'h00);
        tick();
        host_write(mapper_pkg::REG_CTRL, 8'h01);
        check_eq("cpu_rst", 0, cpu_rst);
        tick();
        check_eq("cpu_rst", 1, cpu_rst);
        host_write(mapper_pkg::REG_CTRL, 8'h02);
        check_eq("cpu_halt_n", 0, cpu_halt_n);
        check_eq("cpu_rst", 1, cpu_rst);
        tick();
        check_eq("cpu_rst", 0, cpu_rst);
        host_write(mapper_pkg::REG_CTRL, 8'h00);
        check_eq("cpu_halt_n", 1, cpu_halt_n);
        tick();
        host_read_check(mapper_pkg::REG_CTRL);

        $display("Simulation passed");
        $finish;
    end

endmodule

/* mapper.f */
rtl/mapper_pkg.sv
rtl/mapper_regs.sv
rtl/region_decode.sv
rtl/dtack_gen.sv
rtl/irq_ctrl.sv
rtl/mapper_top.sv
bench/mapper_tb.sv

/* rtl/dtack_gen.sv */
`timescale 1ns/1ps

module dtack_gen (
    input  logic               clk,
    input  logic               rst,
    input  logic               as_n,
    input  mapper_pkg::dtack_e dtack_mode,
    input  logic               ext_dack_n,
    output logic               dtack_n
);

    logic [1:0] wait_cnt;   // edges already seen with as_n low

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= 2'd0;
            dtack_n  <= 1'b1;
        end else if (as_n) begin
            wait_cnt <= 2'd0;   // bus cycle over
            dtack_n  <= 1'b1;
        end else begin
            if (wait_cnt != 2'd3) begin
                wait_cnt <= wait_cnt + 2'd1;   // saturates
            end
            if (dtack_mode == mapper_pkg::DTACK_EXT) begin
                if (!ext_dack_n) begin
                    dtack_n <= 1'b0;
                end
            end else if (wait_cnt >= 2'(dtack_mode)) begin
                // DTACK_1 fires on the first low edge, DTACK_3 two edges later
                dtack_n <= 1'b0;
            end
        end
    end

endmodule

/* rtl/irq_ctrl.sv */
`timescale 1ns/1ps

module irq_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       vint,
    input  logic       as_n,
    input  logic [2:0] fc,
    input  logic [2:0] ipl_prog,
    output logic [2:0] ipl_n,
    output logic       vpa_n,
    output logic       int_ack
);

    logic vint_l;       // previous vint sample
    logic vb_pending;

    // fc 7 with as_n low is an interrupt acknowledge cycle
    assign int_ack = ~as_n & (&fc);
    assign vpa_n   = ~int_ack;   // autovector

    always_ff @(posedge clk) begin
        vint_l <= vint;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vb_pending <= 1'b0;
        end else if (int_ack) begin
            vb_pending <= 1'b0;     // ack wins over a new edge
        end else if (vint && !vint_l) begin
            vb_pending <= 1'b1;
        end
    end

    // vblank overrides the host level
    assign ipl_n = vb_pending ? mapper_pkg::IPL_VBLANK : ipl_prog;

endmodule

/* rtl/mapper_pkg.sv */
package mapper_pkg;

    localparam int NUM_REGIONS = 8;

    // host register map in byte addresses
    localparam logic [4:0] REG_CTRL    = 5'd2;  // bit 0 reset req, bit 1 halt req
    localparam logic [4:0] REG_SND     = 5'd3;  // host to sound cpu
    localparam logic [4:0] REG_IPL     = 5'd4;
    localparam logic [4:0] REG_REGION0 = 5'd16; // config at 16+2i, base at 17+2i

    // active-low interrupt levels
    localparam logic [2:0] IPL_IDLE   = 3'd7;   // no interrupt
    localparam logic [2:0] IPL_VBLANK = 3'd3;   // level 4

    // how many top address bits take part in the compare
    typedef enum logic [1:0] {
        SIZE_64K  = 2'd0,   // 23:16
        SIZE_128K = 2'd1,   // 23:17
        SIZE_512K = 2'd2,   // 23:19
        SIZE_2M   = 2'd3    // 23:21
    } size_e;

    typedef enum logic [1:0] {
        DTACK_1   = 2'd0,
        DTACK_2   = 2'd1,
        DTACK_3   = 2'd2,
        DTACK_EXT = 2'd3    // wait for the external ack pin
    } dtack_e;

    typedef struct packed {
        logic [7:0] base;
        dtack_e     dtack;  // config byte bits 3:2
        size_e      size;   // config byte bits 1:0
    } region_cfg_t;

    // single-cycle host strobes
    typedef struct packed {
        logic       wr;
        logic       rd;
        logic [4:0] addr;
        logic [7:0] data;
    } host_req_t;

    typedef struct packed {
        logic [23:1] addr;  // word address
        logic        as_n;
        logic [2:0]  fc;
    } cpu_bus_t;

endpackage

/* rtl/mapper_regs.sv */
`timescale 1ns/1ps

module mapper_regs (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  mapper_pkg::host_req_t                                  host,
    input  logic                                                   snd_wr,
    input  logic [7:0]                                             snd_din,
    input  logic                                                   snd_rd,
    input  logic                                                   int_ack,
    output logic [7:0]                                             host_dout,
    output logic [7:0]                                             snd_dout,
    output logic                                                   snd_full,
    output logic                                                   snd_intn,
    output mapper_pkg::region_cfg_t [mapper_pkg::NUM_REGIONS-1:0]  region_cfg,
    output logic [2:0]                                             ipl_prog,
    output logic                                                   cpu_rst,
    output logic                                                   cpu_halt_n
);

    logic [7:0] mmr [0:31];
    logic [7:0] snd_latch;  // byte from the sound cpu
    logic [7:0] status;
    logic       host_snd_wr;
    logic       host_snd_rd;

    assign host_snd_wr = host.wr && host.addr == mapper_pkg::REG_SND;
    assign host_snd_rd = host.rd && host.addr == mapper_pkg::REG_SND;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                mmr[i] <= (i == mapper_pkg::REG_IPL) ? {5'd0, mapper_pkg::IPL_IDLE} : 8'd0;
            end
        end else begin
            if (host.wr) begin
                mmr[host.addr] <= host.data;
            end
            // acknowledge drops the programmed level back to idle
            if (int_ack) begin
                mmr[mapper_pkg::REG_IPL][2:0] <= mapper_pkg::IPL_IDLE;
            end
        end
    end

    // sound mailbox
    always_ff @(posedge clk) begin
        if (rst) begin
            snd_full  <= 1'b0;
            snd_intn  <= 1'b1;
            snd_latch <= 8'd0;
        end else begin
            if (host_snd_wr) begin
                snd_full <= 1'b1;   // set beats a same-cycle snd_rd
            end else if (snd_rd) begin
                snd_full <= 1'b0;
            end
            if (snd_wr) begin
                snd_latch <= snd_din;
                snd_intn  <= 1'b0;
            end
            if (host_snd_rd) begin
                snd_intn <= 1'b1;   // host has taken the byte
            end
        end
    end

    assign snd_dout = mmr[mapper_pkg::REG_SND];

    assign status = {snd_full, snd_intn, cpu_rst, cpu_halt_n, 1'b0, ipl_prog};

    // readback valid the cycle after rd
    always_ff @(posedge clk) begin
        if (rst) begin
            host_dout <= 8'd0;
        end else if (host.rd) begin
            case (host.addr)
                mapper_pkg::REG_CTRL: host_dout <= status;
                mapper_pkg::REG_SND:  host_dout <= snd_latch;
                default:              host_dout <= mmr[host.addr];
            endcase
        end
    end

    for (genvar i = 0; i < mapper_pkg::NUM_REGIONS; i++) begin : g_region
        localparam int CFG_ADDR = mapper_pkg::REG_REGION0 + 2 * i;

        assign region_cfg[i] = '{
            base:  mmr[CFG_ADDR + 1],
            dtack: mapper_pkg::dtack_e'(mmr[CFG_ADDR][3:2]),
            size:  mapper_pkg::size_e'(mmr[CFG_ADDR][1:0])
        };
    end

    assign ipl_prog = mmr[mapper_pkg::REG_IPL][2:0];

    // held through reset and one cycle past it
    always_ff @(posedge clk) begin
        cpu_rst <= rst | mmr[mapper_pkg::REG_CTRL][0];
    end

    assign cpu_halt_n = ~mmr[mapper_pkg::REG_CTRL][1];

endmodule

/* rtl/mapper_top.sv */
`timescale 1ns/1ps

module mapper_top (
    input  logic                                clk,
    input  logic                                rst,
    input  mapper_pkg::host_req_t               host,
    input  mapper_pkg::cpu_bus_t                cpu,
    input  logic                                ext_dack_n,
    input  logic                                vint,
    input  logic                                snd_wr,
    input  logic [7:0]                          snd_din,
    input  logic                                snd_rd,
    output logic [7:0]                          host_dout,
    output logic [mapper_pkg::NUM_REGIONS-1:0]  active,
    output logic                                dtack_n,
    output logic [2:0]                          ipl_n,
    output logic                                vpa_n,
    output logic [7:0]                          snd_dout,
    output logic                                snd_full,
    output logic                                snd_intn,
    output logic                                cpu_rst,
    output logic                                cpu_halt_n
);

    mapper_pkg::region_cfg_t [mapper_pkg::NUM_REGIONS-1:0] region_cfg;
    mapper_pkg::dtack_e                                    dtack_mode;
    logic                                                  int_ack;
    logic [2:0]                                            ipl_prog;

    mapper_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .host       (host),
        .snd_wr     (snd_wr),
        .snd_din    (snd_din),
        .snd_rd     (snd_rd),
        .int_ack    (int_ack),
        .host_dout  (host_dout),
        .snd_dout   (snd_dout),
        .snd_full   (snd_full),
        .snd_intn   (snd_intn),
        .region_cfg (region_cfg),
        .ipl_prog   (ipl_prog),
        .cpu_rst    (cpu_rst),
        .cpu_halt_n (cpu_halt_n)
    );

    region_decode u_decode (
        .cpu        (cpu),
        .region_cfg (region_cfg),
        .int_ack    (int_ack),
        .active     (active),
        .dtack_mode (dtack_mode)
    );

    dtack_gen u_dtack (
        .clk        (clk),
        .rst        (rst),
        .as_n       (cpu.as_n),
        .dtack_mode (dtack_mode),
        .ext_dack_n (ext_dack_n),
        .dtack_n    (dtack_n)
    );

    irq_ctrl u_irq (
        .clk      (clk),
        .rst      (rst),
        .vint     (vint),
        .as_n     (cpu.as_n),
        .fc       (cpu.fc),
        .ipl_prog (ipl_prog),
        .ipl_n    (ipl_n),
        .vpa_n    (vpa_n),
        .int_ack  (int_ack)
    );

endmodule

/* rtl/region_decode.sv */
`timescale 1ns/1ps

module region_decode (
    input  mapper_pkg::cpu_bus_t                                  cpu,
    input  mapper_pkg::region_cfg_t [mapper_pkg::NUM_REGIONS-1:0] region_cfg,
    input  logic                                                  int_ack,
    output logic [mapper_pkg::NUM_REGIONS-1:0]                    active,
    output mapper_pkg::dtack_e                                    dtack_mode
);

    logic [mapper_pkg::NUM_REGIONS-1:0] hit;

    // per-region compare, width set by the size code
    always_comb begin
        for (int i = 0; i < mapper_pkg::NUM_REGIONS; i++) begin
            hit[i] = 1'b0;
            case (region_cfg[i].size)
                mapper_pkg::SIZE_64K:  hit[i] = cpu.addr[23:16] == region_cfg[i].base;
                mapper_pkg::SIZE_128K: hit[i] = cpu.addr[23:17] == region_cfg[i].base[7:1];
                mapper_pkg::SIZE_512K: hit[i] = cpu.addr[23:19] == region_cfg[i].base[7:3];
                mapper_pkg::SIZE_2M:   hit[i] = cpu.addr[23:21] == region_cfg[i].base[7:5];
                default:               hit[i] = 1'b0;
            endcase
        end
    end

    always_comb begin
        active     = '0;
        dtack_mode = mapper_pkg::DTACK_1;
        // scan downwards so region 0 has the last word
        for (int i = mapper_pkg::NUM_REGIONS - 1; i >= 0; i--) begin
            if (hit[i]) begin
                active     = '0;
                active[i]  = 1'b1;
                dtack_mode = region_cfg[i].dtack;
            end
        end
        if (int_ack) begin
            active     = '0;    // no memory cycle during irq ack
            dtack_mode = mapper_pkg::DTACK_1;
        end
    end

endmodule
